// File: hw/pyr_cfg.svh
`ifndef PYR_CFG_SVH
`define PYR_CFG_SVH

// source frame size in pixels, both even
`define PYR_IMG_WIDTH 8
`define PYR_IMG_HEIGHT 8

// clocks per uart bit
// 16 at 100 MHz gives 6.25 Mbaud
`define PYR_CLKS_PER_BAUD 16

`endif

// File: hw/pyr_pkg.sv
`default_nettype none

`include "pyr_cfg.svh"

package pyr_pkg;

    typedef logic [7:0] pixel_t;  // one greyscale sample

    typedef logic [$clog2(`PYR_IMG_WIDTH * `PYR_IMG_HEIGHT)-1:0] src_addr_t;
    typedef logic [$clog2(`PYR_IMG_WIDTH * `PYR_IMG_HEIGHT / 4)-1:0] half_addr_t;

    // write port of the source frame ram
    typedef struct packed {
        logic      en;
        src_addr_t addr;
        pixel_t    data;
    } src_wr_t;

    // write port of the reduced frame ram
    typedef struct packed {
        logic       en;
        half_addr_t addr;
        pixel_t     data;
    } half_wr_t;

    typedef enum logic [1:0] {
        st_idle,
        st_read,   // four block reads back to back
        st_sum,    // last read data lands
        st_write
    } reduce_state_t;

endpackage

`default_nettype wire

// File: hw/uart_rx.sv
`default_nettype none

`include "pyr_cfg.svh"

module uart_rx (
    input  wire             clk_100mhz,
    input  wire             sys_rst,
    input  wire             rx_i,
    output pyr_pkg::pixel_t data_o,
    output logic            valid_o
);
    import pyr_pkg::*;

    localparam int CLKS = `PYR_CLKS_PER_BAUD;
    localparam int CW   = $clog2(CLKS);

    typedef enum logic [1:0] {rx_idle, rx_start, rx_bits, rx_stop} rx_state_t;

    rx_state_t     state;
    logic          rx_meta;
    logic          rx_sync;
    logic          rx_prev;  // for the falling start edge
    logic [CW-1:0] baud_cnt;
    logic [2:0]    bit_cnt;
    pixel_t        shift;

    // two flop synchronizer, idles high
    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            state    <= rx_idle;
            valid_o  <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            valid_o <= 1'b0;
            case (state)
                rx_idle: begin
                    baud_cnt <= '0;
                    if (rx_prev && !rx_sync) state <= rx_start;
                end
                rx_start: begin  // half a bit to the middle of the start bit
                    if (baud_cnt == CW'(CLKS / 2 - 1)) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync ? rx_idle : rx_bits;  // glitch, back to idle
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                rx_bits: begin
                    if (baud_cnt == CW'(CLKS - 1)) begin
                        baud_cnt <= '0;
                        shift    <= {rx_sync, shift[7:1]};  // lsb first
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= rx_stop;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (baud_cnt == CW'(CLKS - 1)) begin
                        baud_cnt <= '0;
                        state    <= rx_idle;
                        if (rx_sync) begin  // bad stop bit drops the byte
                            valid_o <= 1'b1;
                            data_o  <= shift;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`default_nettype none

`include "pyr_cfg.svh"

module uart_tx (
    input  wire             clk_100mhz,
    input  wire             sys_rst,
    input  wire pyr_pkg::pixel_t data_i,
    input  wire             start_i,
    output logic            tx_o,
    output logic            busy_o
);
    localparam int CLKS = `PYR_CLKS_PER_BAUD;
    localparam int CW   = $clog2(CLKS);

    logic [CW-1:0] baud_cnt;
    logic [3:0]    bit_cnt;  // 0 is the start bit, 9 the stop bit
    logic [8:0]    shift;    // data bits, stop bit on top

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            tx_o     <= 1'b1;
            busy_o   <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy_o) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            if (start_i) begin
                shift  <= {1'b1, data_i};
                tx_o   <= 1'b0;  // start bit
                busy_o <= 1'b1;
            end
        end else if (baud_cnt == CW'(CLKS - 1)) begin
            baud_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                busy_o <= 1'b0;  // end of stop bit, line already high
            end else begin
                tx_o    <= shift[0];
                shift   <= {1'b1, shift[8:1]};
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/pixel_ram.sv
`default_nettype none

module pixel_ram #(
    parameter int DEPTH = 64
) (
    input  wire                      clk_100mhz,
    input  wire [$clog2(DEPTH)-1:0]  wr_addr_i,
    input  wire pyr_pkg::pixel_t     wr_data_i,
    input  wire                      wr_en_i,
    input  wire [$clog2(DEPTH)-1:0]  rd_addr_i,
    output pyr_pkg::pixel_t          rd_data_o
);
    import pyr_pkg::*;

    pixel_t mem [DEPTH];

    // a read of the written address returns the old word
    always_ff @(posedge clk_100mhz) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

// File: hw/pyramid_reduce.sv
`default_nettype none

`include "pyr_cfg.svh"

module pyramid_reduce (
    input  wire                 clk_100mhz,
    input  wire                 sys_rst,
    input  wire                 start_i,
    output pyr_pkg::src_addr_t  src_rd_addr_o,
    input  wire pyr_pkg::pixel_t src_pixel_i,
    output pyr_pkg::half_wr_t   half_wr_o,
    output logic                done_o
);
    import pyr_pkg::*;

    localparam int HALF_W = `PYR_IMG_WIDTH / 2;
    localparam int HALF_H = `PYR_IMG_HEIGHT / 2;
    localparam int BXW    = $clog2(HALF_W);
    localparam int BYW    = $clog2(HALF_H);

    reduce_state_t  state;
    logic [BXW-1:0] bx;    // block column
    logic [BYW-1:0] by;    // block row
    logic [1:0]     quad;  // pixel inside the block, bit 1 picks the row
    logic [9:0]     acc;   // four 8 bit pixels
    logic           last_block;
    logic           last_col;

    assign last_col   = (bx == BXW'(HALF_W - 1));
    assign last_block = last_col && (by == BYW'(HALF_H - 1));

    // source pixel of the current block and quad
    assign src_rd_addr_o = src_addr_t'({by, quad[1]} * `PYR_IMG_WIDTH + {bx, quad[0]});

    always_comb begin
        half_wr_o.en   = (state == st_write);
        half_wr_o.addr = half_addr_t'(by * HALF_W + bx);
        half_wr_o.data = acc[9:2];  // floor of sum / 4
    end

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            state  <= st_idle;
            bx     <= '0;
            by     <= '0;
            quad   <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                st_idle: begin
                    if (start_i) begin
                        bx    <= '0;
                        by    <= '0;
                        quad  <= '0;
                        state <= st_read;
                    end
                end
                st_read: begin
                    quad <= quad + 2'd1;  // wraps back to 0 for the next block
                    if (quad == 2'd3) state <= st_sum;
                end
                st_sum: state <= st_write;
                st_write: begin
                    if (last_block) begin
                        state  <= st_idle;
                        done_o <= 1'b1;
                    end else begin
                        state <= st_read;
                        if (last_col) begin
                            bx <= '0;
                            by <= by + 1'b1;
                        end else begin
                            bx <= bx + 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // ram data trails the address by one cycle
    always_ff @(posedge clk_100mhz) begin
        if (state == st_read && quad == 2'd0) begin
            acc <= '0;
        end else if (state == st_read || state == st_sum) begin
            acc <= acc + 10'(src_pixel_i);
        end
    end

endmodule

`default_nettype wire

// File: hw/image_sender.sv
`default_nettype none

`include "pyr_cfg.svh"

module image_sender (
    input  wire                 clk_100mhz,
    input  wire                 sys_rst,
    input  wire                 send_i,
    output pyr_pkg::half_addr_t rd_addr_o,
    input  wire pyr_pkg::pixel_t pixel_i,
    output logic                tx_o,
    output logic                busy_o
);
    import pyr_pkg::*;

    localparam int LAST_ADDR = `PYR_IMG_WIDTH * `PYR_IMG_HEIGHT / 4 - 1;

    typedef enum logic [1:0] {snd_idle, snd_fetch, snd_start, snd_wait} snd_state_t;

    snd_state_t state;
    logic       tx_start;
    logic       tx_busy;

    assign tx_start = (state == snd_start);  // pixel_i valid here
    assign busy_o   = (state != snd_idle);

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            state     <= snd_idle;
            rd_addr_o <= '0;
        end else begin
            case (state)
                snd_idle: begin
                    rd_addr_o <= '0;
                    if (send_i) state <= snd_fetch;
                end
                snd_fetch: state <= snd_start;  // ram read latency
                snd_start: state <= snd_wait;   // tx busy rises next cycle
                snd_wait: begin
                    if (!tx_busy) begin
                        if (rd_addr_o == half_addr_t'(LAST_ADDR)) begin
                            state <= snd_idle;
                        end else begin
                            rd_addr_o <= rd_addr_o + 1'b1;
                            state     <= snd_fetch;
                        end
                    end
                end
                default: state <= snd_idle;
            endcase
        end
    end

    uart_tx u_tx (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .data_i     (pixel_i),
        .start_i    (tx_start),
        .tx_o       (tx_o),
        .busy_o     (tx_busy)
    );

endmodule

`default_nettype wire

// File: hw/pyramid_top.sv
`default_nettype none

`include "pyr_cfg.svh"

module pyramid_top (
    input  wire  clk_100mhz,
    input  wire  sys_rst,
    input  wire  uart_rx_i,
    input  wire  send_req_i,
    output logic uart_tx_o,
    output logic frame_loaded_o,
    output logic reduce_done_o
);
    import pyr_pkg::*;

    localparam int SRC_DEPTH  = `PYR_IMG_WIDTH * `PYR_IMG_HEIGHT;
    localparam int HALF_DEPTH = SRC_DEPTH / 4;

    pixel_t     rx_byte;
    logic       rx_valid;
    src_addr_t  wr_cnt;        // next source pixel
    src_wr_t    src_wr;
    half_wr_t   half_wr;
    src_addr_t  src_rd_addr;
    pixel_t     src_rd_data;
    half_addr_t half_rd_addr;
    pixel_t     half_rd_data;
    logic       reduce_start;
    logic       reduce_done;
    logic       send_go;
    logic       sender_busy;

    uart_rx u_rx (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .rx_i       (uart_rx_i),
        .data_o     (rx_byte),
        .valid_o    (rx_valid)
    );

    // frame loader, byte goes to ram the cycle after valid
    always_ff @(posedge clk_100mhz) begin
        src_wr.addr <= wr_cnt;
        src_wr.data <= rx_byte;
        if (sys_rst) begin
            wr_cnt         <= '0;
            src_wr.en      <= 1'b0;
            frame_loaded_o <= 1'b0;
            reduce_done_o  <= 1'b0;
            reduce_start   <= 1'b0;
        end else begin
            src_wr.en    <= rx_valid;
            reduce_start <= 1'b0;
            if (rx_valid) begin
                wr_cnt <= (wr_cnt == src_addr_t'(SRC_DEPTH - 1)) ? '0 : wr_cnt + 1'b1;
            end
            // last pixel just written
            if (src_wr.en && src_wr.addr == src_addr_t'(SRC_DEPTH - 1)) begin
                frame_loaded_o <= 1'b1;
                reduce_start   <= 1'b1;
            end
            if (reduce_done) reduce_done_o <= 1'b1;
            if (rx_valid && wr_cnt == '0) begin  // new frame starts
                frame_loaded_o <= 1'b0;
                reduce_done_o  <= 1'b0;
            end
        end
    end

    pixel_ram #(.DEPTH(SRC_DEPTH)) src_ram (
        .clk_100mhz (clk_100mhz),
        .wr_addr_i  (src_wr.addr),
        .wr_data_i  (src_wr.data),
        .wr_en_i    (src_wr.en),
        .rd_addr_i  (src_rd_addr),
        .rd_data_o  (src_rd_data)
    );

    pyramid_reduce u_reduce (
        .clk_100mhz    (clk_100mhz),
        .sys_rst       (sys_rst),
        .start_i       (reduce_start),
        .src_rd_addr_o (src_rd_addr),
        .src_pixel_i   (src_rd_data),
        .half_wr_o     (half_wr),
        .done_o        (reduce_done)
    );

    pixel_ram #(.DEPTH(HALF_DEPTH)) half_ram (
        .clk_100mhz (clk_100mhz),
        .wr_addr_i  (half_wr.addr),
        .wr_data_i  (half_wr.data),
        .wr_en_i    (half_wr.en),
        .rd_addr_i  (half_rd_addr),
        .rd_data_o  (half_rd_data)
    );

    assign send_go = send_req_i && reduce_done_o && !sender_busy;  // other requests dropped

    image_sender u_sender (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .send_i     (send_go),
        .rd_addr_o  (half_rd_addr),
        .pixel_i    (half_rd_data),
        .tx_o       (uart_tx_o),
        .busy_o     (sender_busy)
    );

endmodule

`default_nettype wire

// File: testbench/pyramid_properties.sv
`default_nettype none

module pyramid_properties (
    input wire                        clk_100mhz,
    input wire                        sys_rst,
    input wire                        uart_tx_o,
    input wire                        sender_busy,
    input wire                        reduce_start,
    input wire                        frame_loaded_o,
    input wire                        reduce_done_o,
    input wire pyr_pkg::reduce_state_t reduce_state,
    input wire pyr_pkg::half_wr_t     half_wr
);
    timeunit 1ns;
    timeprecision 1ps;

    import pyr_pkg::*;

    // serial line rests high between images
    a_tx_idle_high: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        !sender_busy |-> uart_tx_o)
        else $error("uart_tx_o low while the image sender is idle");

    a_start_loaded: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        reduce_start |-> frame_loaded_o)
        else $error("reduce start without a loaded frame");

    // engine rests while no loaded frame waits for reduction
    a_no_idle_write: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        (reduce_done_o || !frame_loaded_o) |-> (reduce_state == st_idle && !half_wr.en))
        else $error("reduce engine active while no loaded frame waits for reduction");

endmodule

`default_nettype wire

// File: testbench/pyramid_tb.sv
`default_nettype none

`include "pyr_cfg.svh"

module pyramid_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import pyr_pkg::*;

    localparam int W         = `PYR_IMG_WIDTH;
    localparam int SRC_N     = `PYR_IMG_WIDTH * `PYR_IMG_HEIGHT;
    localparam int HALF_N    = SRC_N / 4;
    localparam int CLKS      = `PYR_CLKS_PER_BAUD;
    localparam int CHAR_CYC  = 10 * CLKS;
    localparam int NUM_TESTS = 5;
    localparam int LIMIT     = NUM_TESTS * 3 * 80 * CHAR_CYC / 2;  // 1.5 x 80 chars per row

    typedef enum {fill_const, fill_ramp, fill_rand} fill_t;
    typedef struct {
        string  name;
        fill_t  mode;
        pixel_t base;
        bit     early_req;  // pulse send before reduce is done
    } test_row_t;

    test_row_t tests [NUM_TESTS] = '{
        '{"const_gray", fill_const, 8'h5a, 1'b0},
        '{"ramp_low",   fill_ramp,  8'h03, 1'b1},
        '{"ramp_wrap",  fill_ramp,  8'hc7, 1'b0},
        '{"random_a",   fill_rand,  8'h00, 1'b1},
        '{"random_b",   fill_rand,  8'h00, 1'b0}
    };

    logic        clk_100mhz;
    logic        sys_rst;
    logic        uart_rx_i;
    logic        send_req_i;
    logic        uart_tx_o;
    logic        frame_loaded_o;
    logic        reduce_done_o;
    pixel_t      rx_q [$];       // bytes seen on uart_tx_o
    logic        mon_busy;
    logic [15:0] lfsr = 16'd25394;
    int          value_errs = 0;
    int          other_errs = 0;
    int          cycles = 0;

    pyramid_top DUT (
        .clk_100mhz     (clk_100mhz),
        .sys_rst        (sys_rst),
        .uart_rx_i      (uart_rx_i),
        .send_req_i     (send_req_i),
        .uart_tx_o      (uart_tx_o),
        .frame_loaded_o (frame_loaded_o),
        .reduce_done_o  (reduce_done_o)
    );

    bind pyramid_top pyramid_properties u_props (
        .clk_100mhz     (clk_100mhz),
        .sys_rst        (sys_rst),
        .uart_tx_o      (uart_tx_o),
        .sender_busy    (sender_busy),
        .reduce_start   (reduce_start),
        .frame_loaded_o (frame_loaded_o),
        .reduce_done_o  (reduce_done_o),
        .reduce_state   (u_reduce.state),
        .half_wr        (half_wr)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        if (act !== exp) begin
            value_errs++;
            $display("Fail %s: expected %02h, actual %02h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input bit exp, input logic act);
        if (act !== exp) begin
            value_errs++;
            $display("Fail %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            value_errs++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // starts and ends 1 ns after a rising edge
    task automatic send_byte(input pixel_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rx_i = frame[i];
            repeat (CLKS) @(posedge clk_100mhz);
            #1;
        end
    endtask

    task automatic pulse_request();
        send_req_i = 1'b1;
        @(posedge clk_100mhz);
        #1;
        send_req_i = 1'b0;
    endtask

    initial begin
        clk_100mhz = 1'b0;
        forever #5 clk_100mhz = ~clk_100mhz;
    end

    // uart monitor samples mid bit on the falling clock
    initial begin : monitor
        pixel_t b;
        mon_busy = 1'b0;
        forever begin
            @(negedge clk_100mhz);
            if (!sys_rst && uart_tx_o === 1'b0) begin
                mon_busy = 1'b1;
                repeat (CLKS / 2 - 1) @(negedge clk_100mhz);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS) @(negedge clk_100mhz);
                    b[i] = uart_tx_o;
                end
                repeat (CLKS) @(negedge clk_100mhz);
                if (uart_tx_o !== 1'b1) begin
                    other_errs++;
                    $display("stop bit of a byte from the DUT was low");
                end
                rx_q.push_back(b);
                mon_busy = 1'b0;
            end
        end
    end

    initial begin : watchdog
        while (cycles < LIMIT) begin
            @(posedge clk_100mhz);
            cycles++;
        end
        other_errs++;
        $display("timeout: run passed %0d cycles without finishing", LIMIT);
        $display("Verification failed");
        $finish;
    end

    initial begin : stimulus
        pixel_t src [SRC_N];
        pixel_t expect_px [HALF_N];
        int     sum;
        int     a;
        string  nm;
        sys_rst    = 1'b1;
        uart_rx_i  = 1'b1;
        send_req_i = 1'b0;
        repeat (16) @(posedge clk_100mhz);
        #1;
        sys_rst = 1'b0;
        @(posedge clk_100mhz);
        #1;
        check_flag("reset tx line", 1'b1, uart_tx_o);
        check_flag("reset frame_loaded", 1'b0, frame_loaded_o);
        check_flag("reset reduce_done", 1'b0, reduce_done_o);

        for (int t = 0; t < NUM_TESTS; t++) begin
            nm = tests[t].name;
            rx_q.delete();
            for (int p = 0; p < SRC_N; p++) begin
                case (tests[t].mode)
                    fill_const: src[p] = tests[t].base;
                    fill_ramp:  src[p] = tests[t].base + pixel_t'(13 * (p % W) + p / W);
                    default: begin
                        for (int k = 0; k < 8; k++) begin  // one step per bit
                            lfsr   = lfsr_next(lfsr);
                            src[p] = {src[p][6:0], lfsr[0]};
                        end
                    end
                endcase
            end
            for (int i = 0; i < HALF_N; i++) begin
                a   = 2 * (i / (W / 2)) * W + 2 * (i % (W / 2));
                sum = src[a] + src[a + 1] + src[a + W] + src[a + W + 1];
                expect_px[i] = pixel_t'(sum / 4);
            end

            for (int p = 0; p < SRC_N; p++) begin
                send_byte(src[p]);
                if (p == 0) begin
                    check_flag({nm, " loaded after first byte"}, 1'b0, frame_loaded_o);
                    check_flag({nm, " done after first byte"}, 1'b0, reduce_done_o);
                    if (tests[t].early_req) pulse_request();
                end
                if (p == SRC_N - 2) check_flag({nm, " loaded before last"}, 1'b0, frame_loaded_o);
            end
            check_flag({nm, " loaded after last"}, 1'b1, frame_loaded_o);
            check_flag({nm, " done right after last"}, 1'b0, reduce_done_o);
            if (tests[t].early_req) pulse_request();  // reduce still running

            while (!reduce_done_o) begin
                @(posedge clk_100mhz);
                #1;
            end
            check_count({nm, " bytes before request"}, 0, rx_q.size());
            check_flag({nm, " monitor idle before request"}, 1'b0, mon_busy);
            pulse_request();
            repeat (3 * CHAR_CYC / 2) @(posedge clk_100mhz);
            #1;
            pulse_request();  // sender busy so this one is dropped
            while (rx_q.size() < HALF_N) begin
                @(posedge clk_100mhz);
                #1;
            end
            repeat (2 * CHAR_CYC) @(posedge clk_100mhz);
            #1;
            check_count({nm, " byte count"}, HALF_N, rx_q.size());
            for (int i = 0; i < HALF_N && i < rx_q.size(); i++) begin
                check_pixel($sformatf("%s pixel %0d", nm, i), expect_px[i], rx_q[i]);
            end
        end

        $display("errors: %0d value mismatches, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hw
hw/pyr_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/pixel_ram.sv
hw/pyramid_reduce.sv
hw/image_sender.sv
hw/pyramid_top.sv
testbench/pyramid_properties.sv
testbench/pyramid_tb.sv
